//--- hdl/frontPkg.sv
`default_nettype none

package frontPkg;

  // Instruction memory depth in words
  localparam int MEM_WORDS = 32;

  typedef logic [31:0] word_t;
  typedef logic [$clog2(MEM_WORDS)-1:0] addr_t;
  typedef logic [5:0] opc_t;
  typedef logic [4:0] reg_t;
  typedef logic [15:0] imm_t;

  // Opcodes that own the following slot
  localparam opc_t OPC_IMM  = 6'o54;
  localparam opc_t OPC_RTD  = 6'o55;
  localparam opc_t OPC_BRU  = 6'o46;
  localparam opc_t OPC_BRUI = 6'o56;
  localparam opc_t OPC_BCC  = 6'o47;
  localparam opc_t OPC_BCCI = 6'o57;

  // Branch-and-link to the interrupt vector, link in r14
  localparam word_t INT_OP = {OPC_BRUI, 5'd14, 5'd12, 16'h0060};

  // Requester side of the fetch handshake
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_DROP
  } fetchState_t;

endpackage

`default_nettype wire

//--- hdl/instrMem.sv
`default_nettype none

module instrMem import frontPkg::*; (
  input  wire logic  gclk,
  input  wire logic  reset,
  input  wire logic  fetchReq,
  input  wire addr_t fetchAddr,
  output logic       fetchAck,
  output word_t      fetchData
);

  word_t mem [MEM_WORDS];

  // ROM image
  initial begin
    $readmemh("program.hex", mem);
  end

  // Responder side of the four-phase handshake
  always_ff @(posedge gclk) begin
    if (reset) begin
      fetchAck <= 1'b0;
    end else if (fetchReq && !fetchAck) begin
      fetchAck <= 1'b1;
    end else if (!fetchReq && fetchAck) begin
      fetchAck <= 1'b0;
    end
  end

  // Word is valid together with the rising ack
  always_ff @(posedge gclk) begin
    if (fetchReq && !fetchAck) begin
      fetchData <= mem[fetchAddr];
    end
  end

  // Requester must hold req until it sees the ack
  reqHeldUntilAck: assert property (
    @(posedge gclk) disable iff (reset)
    (fetchReq && !fetchAck) |=> fetchReq
  );

endmodule

`default_nettype wire

//--- hdl/fetchUnit.sv
`default_nettype none

module fetchUnit import frontPkg::*; (
  input  wire logic  gclk,
  input  wire logic  reset,
  input  wire logic  stall,
  input  wire logic  fetchAck,
  input  wire word_t fetchData,
  output logic       fetchReq,
  output addr_t      fetchAddr,
  output logic       dEn,
  output word_t      dInst
);

  fetchState_t state;
  addr_t pc;
  logic capture;

  assign fetchAddr = pc;

  // Word arrives on the first cycle ack is seen high
  assign capture = (state == REQ) && fetchAck;

  always_ff @(posedge gclk) begin
    if (reset) begin
      state    <= IDLE;
      fetchReq <= 1'b0;
      dEn      <= 1'b0;
      pc       <= '0;
    end else begin
      dEn <= 1'b0;
      case (state)
        IDLE: begin
          // Stall only holds off a new request
          if (!stall) begin
            state    <= REQ;
            fetchReq <= 1'b1;
          end
        end
        REQ: begin
          if (fetchAck) begin
            state    <= WAIT_DROP;
            fetchReq <= 1'b0;
            dEn      <= 1'b1;
            pc       <= pc + addr_t'(1);
          end
        end
        WAIT_DROP: begin
          // Return to zero before the next request
          if (!fetchAck) begin
            if (stall) begin
              state <= IDLE;
            end else begin
              state    <= REQ;
              fetchReq <= 1'b1;
            end
          end
        end
        default: begin
          state    <= IDLE;
          fetchReq <= 1'b0;
        end
      endcase
    end
  end

  // Held for the buffer until the next capture
  always_ff @(posedge gclk) begin
    if (capture) begin
      dInst <= fetchData;
    end
  end

  addrStableDuringReq: assert property (
    @(posedge gclk) disable iff (reset)
    fetchReq |=> (!fetchReq || $stable(fetchAddr))
  );

endmodule

`default_nettype wire

//--- hdl/instrBuffer.sv
`default_nettype none

module instrBuffer import frontPkg::*; (
  input  wire logic  gclk,
  input  wire logic  reset,
  input  wire logic  dEn,
  input  wire word_t dInst,
  input  wire logic  msrIe,
  input  wire logic  intReq,
  output logic       issueValid,
  output opc_t       issueOpc,
  output reg_t       issueRd,
  output reg_t       issueRa,
  output reg_t       issueRb,
  output imm_t       issueImm,
  output word_t      issueImmVal,
  output logic       intTaken
);

  logic [1:0] intSync;
  logic intPend;
  logic prevImm;
  logic prevBlock;
  logic doInt;
  logic blocking;
  word_t nextInst;
  opc_t nextOpc;
  word_t immVal;

  // Two flops on the async request, held clear while interrupts are off
  always_ff @(posedge gclk) begin
    if (reset || !msrIe) begin
      intSync <= '0;
    end else begin
      intSync <= {intSync[0], intReq};
    end
  end

  // Pending latch on the synchronized level
  always_ff @(posedge gclk) begin
    if (reset) begin
      intPend <= 1'b0;
    end else if (intTaken || !msrIe) begin
      intPend <= 1'b0;
    end else if (intSync[1]) begin
      intPend <= 1'b1;
    end
  end

  // Not allowed after IMM, RTD or a branch since that slot belongs to them
  assign doInt = dEn && intPend && !intTaken && !prevBlock;

  assign nextInst = doInt ? INT_OP : dInst;
  assign nextOpc  = nextInst[31:26];

  assign blocking = (nextOpc == OPC_IMM) || (nextOpc == OPC_RTD) ||
                    (nextOpc == OPC_BRU) || (nextOpc == OPC_BRUI) ||
                    (nextOpc == OPC_BCC) || (nextOpc == OPC_BCCI);

  // IMM prefix supplies the upper half, else sign extend
  assign immVal = prevImm ? {issueImm, nextInst[15:0]}
                          : {{16{nextInst[15]}}, nextInst[15:0]};

  always_ff @(posedge gclk) begin
    if (reset) begin
      issueValid <= 1'b0;
      intTaken   <= 1'b0;
      prevImm    <= 1'b0;
      prevBlock  <= 1'b0;
    end else begin
      issueValid <= dEn;
      intTaken   <= doInt;
      if (dEn) begin
        prevImm   <= (nextOpc == OPC_IMM);
        prevBlock <= blocking;
      end
    end
  end

  // Issue fields
  always_ff @(posedge gclk) begin
    if (dEn) begin
      issueOpc    <= nextOpc;
      issueRd     <= nextInst[25:21];
      issueRa     <= nextInst[20:16];
      issueRb     <= nextInst[15:11];
      issueImm    <= nextInst[15:0];
      issueImmVal <= immVal;
    end
  end

  // Fetch sends one decode enable per word, never back to back
  decodeIsPulse: assert property (
    @(posedge gclk) disable iff (reset)
    dEn |=> !dEn
  );

endmodule

`default_nettype wire

//--- hdl/frontEnd.sv
`default_nettype none

module frontEnd import frontPkg::*; (
  input  wire logic  gclk,
  input  wire logic  reset,
  input  wire logic  stall,
  input  wire logic  msrIe,
  input  wire logic  intReq,
  output wire logic  issueValid,
  output wire opc_t  issueOpc,
  output wire reg_t  issueRd,
  output wire reg_t  issueRa,
  output wire reg_t  issueRb,
  output wire imm_t  issueImm,
  output wire word_t issueImmVal,
  output wire logic  intTaken
);

  // Fetch handshake
  wire logic  fetchReq;
  wire logic  fetchAck;
  wire addr_t fetchAddr;
  wire word_t fetchData;

  // Fetch to buffer
  wire logic  dEn;
  wire word_t dInst;

  fetchUnit fetch0 (
    .gclk      (gclk),
    .reset     (reset),
    .stall     (stall),
    .fetchAck  (fetchAck),
    .fetchData (fetchData),
    .fetchReq  (fetchReq),
    .fetchAddr (fetchAddr),
    .dEn       (dEn),
    .dInst     (dInst)
  );

  instrMem mem0 (
    .gclk      (gclk),
    .reset     (reset),
    .fetchReq  (fetchReq),
    .fetchAddr (fetchAddr),
    .fetchAck  (fetchAck),
    .fetchData (fetchData)
  );

  instrBuffer ibuf0 (
    .gclk        (gclk),
    .reset       (reset),
    .dEn         (dEn),
    .dInst       (dInst),
    .msrIe       (msrIe),
    .intReq      (intReq),
    .issueValid  (issueValid),
    .issueOpc    (issueOpc),
    .issueRd     (issueRd),
    .issueRa     (issueRa),
    .issueRb     (issueRb),
    .issueImm    (issueImm),
    .issueImmVal (issueImmVal),
    .intTaken    (intTaken)
  );

endmodule

`default_nettype wire

//--- bench/clockGen.sv
`default_nettype none

module clockGen (
  output logic gclk,
  output logic reset
);

  // Period 100
  initial begin
    gclk = 1'b0;
    forever #50 gclk = ~gclk;
  end

  // Reset held over the first 3 rising edges
  initial begin
    reset = 1'b1;
    repeat (3) @(posedge gclk);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- bench/frontEndTb.sv
`default_nettype none

module frontEndTb;

  localparam int NUM_PHASES = 6;
  // Branch-and-link r14 to vector 0x60
  localparam logic [31:0] INT_WORD = {6'o56, 5'd14, 5'd12, 16'h0060};

  typedef struct packed {
    int         issues;
    logic [1:0] stallMode;
    logic       ie;
    int         intAt;
  } phase_t;

  // Issues, stall mode (0 none, 1 random, 2 alternate), msrIe, pulse after issue n
  localparam phase_t PHASES [NUM_PHASES] = '{
    '{40, 2'd0, 1'b0, 0},
    '{24, 2'd0, 1'b1, 1},
    '{16, 2'd0, 1'b0, 2},
    '{40, 2'd1, 1'b0, 0},
    '{20, 2'd2, 1'b1, 5},
    '{12, 2'd0, 1'b1, 3}
  };

  logic gclk;
  logic reset;
  logic stall = 1'b0;
  logic msrIe = 1'b0;
  logic intReq = 1'b0;
  logic issueValid;
  logic [5:0] issueOpc;
  logic [4:0] issueRd;
  logic [4:0] issueRa;
  logic [4:0] issueRb;
  logic [15:0] issueImm;
  logic [31:0] issueImmVal;
  logic intTaken;

  // Reference model state
  logic [31:0] progMem [32];
  logic [4:0] expAddr = 5'd0;
  logic [15:0] mImmHi = 16'h0;
  logic mPrevImm = 1'b0;
  logic mPrevBlock = 1'b0;
  logic mSync0 = 1'b0;
  logic mSync1 = 1'b0;
  logic mPend = 1'b0;
  logic ieLast = 1'b0;
  logic reqLast = 1'b0;
  logic takenLast = 1'b0;

  int errors = 0;
  int checks = 0;
  int issuesSeen = 0;
  int issuesInPhase = 0;
  int injections = 0;
  int requests = 0;
  int deferrals = 0;
  int cycles = 0;
  int limit = 0;
  logic [2:0] curPhase = 3'd0;
  logic intReqNext = 1'b0;
  logic done = 1'b0;
  integer seed = 32'h9772;

  clockGen clk0 (
    .gclk  (gclk),
    .reset (reset)
  );

  frontEnd dut0 (
    .gclk        (gclk),
    .reset       (reset),
    .stall       (stall),
    .msrIe       (msrIe),
    .intReq      (intReq),
    .issueValid  (issueValid),
    .issueOpc    (issueOpc),
    .issueRd     (issueRd),
    .issueRa     (issueRa),
    .issueRb     (issueRb),
    .issueImm    (issueImm),
    .issueImmVal (issueImmVal),
    .intTaken    (intTaken)
  );

  // IMM, RTD and the branches own the slot that follows them
  function automatic logic ownsNextSlot(input logic [5:0] opc);
    return (opc == 6'o54) || (opc == 6'o55) || (opc == 6'o46) ||
           (opc == 6'o56) || (opc == 6'o47) || (opc == 6'o57);
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkIssue(input logic expInt);
    logic [31:0] w;
    logic [31:0] immVal;
    w = expInt ? INT_WORD : progMem[expAddr];
    immVal = mPrevImm ? {mImmHi, w[15:0]} : {{16{w[15]}}, w[15:0]};
    checkValue("issueOpc", 32'(issueOpc), 32'(w[31:26]));
    checkValue("issueRd", 32'(issueRd), 32'(w[25:21]));
    checkValue("issueRa", 32'(issueRa), 32'(w[20:16]));
    checkValue("issueRb", 32'(issueRb), 32'(w[15:11]));
    checkValue("issueImm", 32'(issueImm), 32'(w[15:0]));
    checkValue("issueImmVal", issueImmVal, immVal);
    checkValue("intTaken", 32'(intTaken), 32'(expInt));
    // An injected op still consumes the fetched slot
    expAddr = expAddr + 5'd1;
    mPrevImm = (w[31:26] == 6'o54);
    mImmHi = w[15:0];
    mPrevBlock = ownsNextSlot(w[31:26]);
    if (intTaken) begin
      injections++;
    end
  endtask

  // Called once per cycle, after the rising edge
  task automatic sampleCycle();
    logic expInt;
    expInt = mPend && !mPrevBlock && !takenLast;
    if (issueValid && mPend && mPrevBlock && !intTaken) begin
      deferrals++;
    end
    // Pending latch, then the two sync stages, from inputs before the edge
    if (takenLast || !ieLast) begin
      mPend = 1'b0;
    end else if (mSync1) begin
      mPend = 1'b1;
    end
    mSync1 = ieLast ? mSync0 : 1'b0;
    mSync0 = ieLast ? reqLast : 1'b0;
    intReqNext = 1'b0;
    if (issueValid) begin
      checkIssue(expInt);
      issuesSeen++;
      issuesInPhase++;
      if (issuesInPhase == PHASES[curPhase].intAt) begin
        intReqNext = 1'b1;
        if (PHASES[curPhase].ie) begin
          requests++;
        end
      end
      if (issuesInPhase == PHASES[curPhase].issues) begin
        issuesInPhase = 0;
        curPhase = curPhase + 3'd1;
        done = (curPhase == 3'(NUM_PHASES));
      end
    end else if (intTaken) begin
      $display("Interrupt taken without an issued instruction at cycle %0d", cycles);
      errors++;
    end
    ieLast = msrIe;
    reqLast = intReq;
    takenLast = intTaken;
  endtask

  // Inputs change on the rising edge only
  always @(posedge gclk) begin
    logic [31:0] rnd;
    rnd = $random(seed);
    if (!reset && !done) begin
      case (PHASES[curPhase].stallMode)
        2'd1: stall <= rnd[0];
        2'd2: stall <= ~stall;
        default: stall <= 1'b0;
      endcase
      msrIe  <= PHASES[curPhase].ie;
      intReq <= intReqNext;
    end
  end

  initial begin
    int total;
    total = 0;
    $readmemh("program.hex", progMem);
    for (logic [2:0] i = 3'd0; i < 3'(NUM_PHASES); i++) begin
      total += PHASES[i].issues;
    end
    limit = 8 * total + 50;
    @(negedge gclk);
    while (reset) begin
      @(negedge gclk);
    end
    while (!done && cycles < limit) begin
      sampleCycle();
      cycles++;
      @(negedge gclk);
    end
    if (!done) begin
      $display("Timeout after %0d cycles, the issue stream stalled at %0d of %0d issues",
               cycles, issuesSeen, total);
      errors++;
    end else begin
      if (injections != requests) begin
        $display("Saw %0d interrupt injections for %0d enabled requests", injections, requests);
        errors++;
      end
      if (deferrals == 0) begin
        $display("No pending interrupt was held back by a blocking slot");
        errors++;
      end
    end
    $display("Checks %0d, errors %0d, issues %0d, interrupts %0d, deferred slots %0d",
             checks, errors, issuesSeen, injections, deferrals);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- program.hex
// One 32-bit instruction word per line, word address 0 to 31
20200005
2041FFFE
00611000
B0001234
20808765
A0A47FFF
B000FFFF
20210001
B60F0008
B8000040
BC03FFF0
98001000
9C042800
B00000AB
B00000CD
20424000
C8611000
D8610000
B60F0008
00000000
B0008000
20A00000
B800FFFC
20217FFF
00842000
20628000
00000000
A04200F0
BC010010
00000000
2020FFFF
00A32000

//--- src.f
hdl/frontPkg.sv
hdl/instrMem.sv
hdl/fetchUnit.sv
hdl/instrBuffer.sv
hdl/frontEnd.sv
bench/clockGen.sv
bench/frontEndTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module frontEndTb \
  -Mdir obj_dir -o frontEndSim -f src.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/frontEndSim)
simStatus=$?
echo "$output"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "STATUS: PASS" <<< "$output"; then
  exit 0
fi
exit 1
